// ==== src/common_pkg.sv ====
package common_pkg;

	// plain word types, no signedness implied
	typedef logic [31:0] u32;
	typedef logic [63:0] u64;

	typedef logic [4:0] u5; // register index

endpackage

// ==== src/pipes_pkg.sv ====
package pipes_pkg;

	// alu operation select, shared with the rest of the core
	typedef enum logic [4:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_S_LESS,
		ALU_U_LESS,
		ALU_L_SL,
		ALU_L_SR,
		ALU_A_SR,
		ALU_ADDW,
		ALU_SUBW,
		ALU_L_SLW,
		ALU_L_SRW,
		ALU_A_SRW,
		ALU_ADDIW,
		ALU_L_SLIW,
		ALU_L_SRIW,
		ALU_A_SRIW,
		ALU_B,         // branch compare, result unused
		ALU_LINK,      // pass rd2 through
		ALU_RS1_ADD_0, // pass rd1 through
		ALU_CSRRW,
		ALU_CSRRS,
		ALU_CSRRC
	} alufunc_t;

	// one instruction word, seen as r-type or i-type
	typedef union packed {
		struct packed {
			logic [6:0]   funct7;
			common_pkg::u5 rs2;
			common_pkg::u5 rs1;
			logic [2:0]   funct3;
			common_pkg::u5 rd;
			logic [6:0]   opcode;
		} r;
		struct packed {
			logic [11:0]  imm12;
			common_pkg::u5 rs1;
			logic [2:0]   funct3;
			common_pkg::u5 rd;
			logic [6:0]   opcode;
		} i;
	} instr_u;

	// major opcodes handled by the execute path
	localparam logic [6:0] OPC_OP        = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
	localparam logic [6:0] OPC_OP_32     = 7'b0111011;
	localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
	localparam logic [6:0] OPC_LUI       = 7'b0110111;

endpackage

// ==== src/pipe_if.sv ====
`timescale 1ns/1ns

// decode register contents handed to execute
interface dec_if;
	import common_pkg::*;
	import pipes_pkg::*;

	logic     valid;
	alufunc_t aluop;
	u64       op1;
	u64       op2;
	u5        rd;

	modport source (output valid, aluop, op1, op2, rd);
	modport sink   (input valid, aluop, op1, op2, rd);
endinterface

// execute result on its way to the register file
interface wb_if;
	import common_pkg::*;

	logic valid;
	u5    rd;
	u64   result;

	modport source  (output valid, rd, result);
	modport sink    (input valid, rd, result);
	modport monitor (input valid, rd, result); // decode peeks for forwarding
endinterface

// ==== src/alu.sv ====
`timescale 1ns/1ns

module alu (
	input  common_pkg::u64      rd1,
	input  common_pkg::u64      rd2,
	input  pipes_pkg::alufunc_t ALUOP,
	output common_pkg::u64      ALU_out
);
	import common_pkg::*;
	import pipes_pkg::*;

	u64 wide;   // full-width scratch, low half kept by w forms
	u32 narrow; // 32-bit shift results

	function automatic u64 sext32(u32 v);
		return {{32{v[31]}}, v};
	endfunction

	always_comb begin
		wide = '0;
		narrow = '0;
		ALU_out = '0;
		case (ALUOP)
			ALU_ADD: ALU_out = rd1 + rd2;
			ALU_SUB: ALU_out = rd1 - rd2;
			ALU_AND: ALU_out = rd1 & rd2;
			ALU_OR:  ALU_out = rd1 | rd2;
			ALU_XOR: ALU_out = rd1 ^ rd2;
			ALU_S_LESS: ALU_out = {63'b0, $signed(rd1) < $signed(rd2)};
			ALU_U_LESS: ALU_out = {63'b0, rd1 < rd2};
			ALU_L_SL: ALU_out = rd1 << rd2[5:0];
			ALU_L_SR: ALU_out = rd1 >> rd2[5:0];
			ALU_A_SR: ALU_out = $signed(rd1) >>> rd2[5:0];
			ALU_ADDW, ALU_ADDIW: begin
				wide = rd1 + rd2;
				ALU_out = sext32(wide[31:0]);
			end
			ALU_SUBW: begin
				wide = rd1 - rd2;
				ALU_out = sext32(wide[31:0]);
			end
			ALU_L_SLW: begin
				narrow = rd1[31:0] << rd2[4:0];
				ALU_out = sext32(narrow);
			end
			ALU_L_SRW: begin
				narrow = rd1[31:0] >> rd2[4:0];
				ALU_out = sext32(narrow);
			end
			ALU_A_SRW: begin
				narrow = $signed(rd1[31:0]) >>> rd2[4:0];
				ALU_out = sext32(narrow);
			end
			ALU_L_SLIW: begin
				wide = rd1 << rd2[5:0];
				ALU_out = sext32(wide[31:0]);
			end
			ALU_L_SRIW: begin
				narrow = rd1[31:0] >> rd2[5:0];
				ALU_out = sext32(narrow);
			end
			ALU_A_SRIW: begin
				// truncate first, then shift in the sign of bit 31
				narrow = $signed(rd1[31:0]) >>> rd2[5:0];
				ALU_out = sext32(narrow);
			end
			ALU_B: ALU_out = '0;
			ALU_LINK: ALU_out = rd2;
			ALU_RS1_ADD_0: ALU_out = rd1;
			ALU_CSRRW: ALU_out = rd1;
			ALU_CSRRS: ALU_out = rd2 | rd1;   // rd2 holds the old csr value
			ALU_CSRRC: ALU_out = rd2 & ~rd1;
			default: ALU_out = '0;
		endcase
	end

endmodule

// ==== src/instr_decode.sv ====
`timescale 1ns/1ns

module instr_decode #(
	parameter int REG_COUNT = 32
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             in_valid,
	input  common_pkg::u32   in_instr,
	output common_pkg::u5    rs1_addr,
	output common_pkg::u5    rs2_addr,
	input  common_pkg::u64   rs1_data,
	input  common_pkg::u64   rs2_data,
	input  logic             ex_fwd_valid,
	input  common_pkg::u5    ex_fwd_rd,
	input  common_pkg::u64   ex_fwd_result,
	dec_if.source            dec,
	wb_if.monitor            wb
);
	import common_pkg::*;
	import pipes_pkg::*;

	instr_u   ins;
	alufunc_t aluop;
	logic     supported;
	logic     use_imm;
	logic     alt;     // funct7[5], picks sub / arithmetic shift
	u64       imm_i;
	u64       imm_u;
	u64       imm;
	u64       rs1_val;
	u64       rs2_val;
	logic     valid_d;

	assign ins = in_instr;
	assign alt = ins.r.funct7[5];

	assign rs1_addr = ins.r.rs1;
	assign rs2_addr = ins.r.rs2;

	// i-type immediate, and the lui immediate rebuilt from the same view
	assign imm_i = {{52{ins.i.imm12[11]}}, ins.i.imm12};
	assign imm_u = {{32{ins.i.imm12[11]}}, ins.i.imm12, ins.i.rs1, ins.i.funct3, 12'h000};

	always_comb begin
		aluop = ALU_ADD;
		supported = 1'b1;
		use_imm = 1'b1;
		imm = imm_i;
		case (ins.r.opcode)
			OPC_OP, OPC_OP_IMM: begin
				use_imm = (ins.r.opcode == OPC_OP_IMM);
				case (ins.r.funct3)
					3'b000: aluop = (alt && !use_imm) ? ALU_SUB : ALU_ADD;
					3'b001: aluop = ALU_L_SL;
					3'b010: aluop = ALU_S_LESS;
					3'b011: aluop = ALU_U_LESS;
					3'b100: aluop = ALU_XOR;
					3'b101: aluop = alt ? ALU_A_SR : ALU_L_SR; // imm bit 10 for srai
					3'b110: aluop = ALU_OR;
					default: aluop = ALU_AND;
				endcase
			end
			OPC_OP_32, OPC_OP_IMM_32: begin
				use_imm = (ins.r.opcode == OPC_OP_IMM_32);
				case (ins.r.funct3)
					3'b000: begin
						if (use_imm)
							aluop = ALU_ADDIW;
						else
							aluop = alt ? ALU_SUBW : ALU_ADDW;
					end
					3'b001: aluop = use_imm ? ALU_L_SLIW : ALU_L_SLW;
					3'b101: begin
						if (use_imm)
							aluop = alt ? ALU_A_SRIW : ALU_L_SRIW;
						else
							aluop = alt ? ALU_A_SRW : ALU_L_SRW;
					end
					default: supported = 1'b0; // no slt/logic ops in the w group
				endcase
			end
			OPC_LUI: begin
				aluop = ALU_LINK; // alu just passes op2
				imm = imm_u;
			end
			default: supported = 1'b0;
		endcase
	end

	// newest value wins: execute, then writeback, then the file
	assign rs1_val = (ex_fwd_valid && ex_fwd_rd == rs1_addr) ? ex_fwd_result :
	                 (wb.valid && wb.rd == rs1_addr)          ? wb.result     : rs1_data;
	assign rs2_val = (ex_fwd_valid && ex_fwd_rd == rs2_addr) ? ex_fwd_result :
	                 (wb.valid && wb.rd == rs2_addr)          ? wb.result     : rs2_data;

	// x0 and indices past the file are never written
	assign valid_d = in_valid && supported && (ins.r.rd != '0) &&
	                 (int'(ins.r.rd) < REG_COUNT);

	always_ff @(posedge clk) begin
		if (!rst_n)
			dec.valid <= 1'b0;
		else
			dec.valid <= valid_d;
	end

	always_ff @(posedge clk) begin
		dec.aluop <= aluop;
		dec.op1 <= rs1_val;
		dec.op2 <= use_imm ? imm : rs2_val;
		dec.rd <= ins.r.rd;
	end

	a_valid_rd: assert property (@(posedge clk) disable iff (!rst_n)
		dec.valid |-> dec.rd != '0);

	a_reset_clear: assert property (@(posedge clk) !rst_n |=> !dec.valid);

endmodule

// ==== src/exec_stage.sv ====
`timescale 1ns/1ns

module exec_stage (
	input  logic           clk,
	input  logic           rst_n,
	dec_if.sink            dec,
	wb_if.source           wb,
	output logic           ex_fwd_valid,
	output common_pkg::u5  ex_fwd_rd,
	output common_pkg::u64 ex_fwd_result
);
	import common_pkg::*;

	u64 alu_out;

	alu alu_i (
		.rd1     (dec.op1),
		.rd2     (dec.op2),
		.ALUOP   (dec.aluop),
		.ALU_out (alu_out)
	);

	// same-cycle bypass back to decode
	assign ex_fwd_valid = dec.valid;
	assign ex_fwd_rd = dec.rd;
	assign ex_fwd_result = alu_out;

	always_ff @(posedge clk) begin
		if (!rst_n)
			wb.valid <= 1'b0;
		else
			wb.valid <= dec.valid;
	end

	always_ff @(posedge clk) begin
		wb.rd <= dec.rd;
		wb.result <= alu_out;
	end

	a_result_match: assert property (@(posedge clk) disable iff (!rst_n)
		wb.valid |-> wb.result == $past(alu_out));

endmodule

// ==== src/reg_writeback.sv ====
`timescale 1ns/1ns

module reg_writeback #(
	parameter int REG_COUNT = 32
) (
	input  logic           clk,
	input  logic           rst_n,
	input  common_pkg::u5  rs1_addr,
	input  common_pkg::u5  rs2_addr,
	wb_if.sink             wb,
	output common_pkg::u64 rs1_data,
	output common_pkg::u64 rs2_data,
	output logic           out_valid,
	output common_pkg::u5  out_rd,
	output common_pkg::u64 out_result
);
	import common_pkg::*;

	localparam int IDX_W = $clog2(REG_COUNT);

	u64 regs [REG_COUNT];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int k = 0; k < REG_COUNT; k++)
				regs[k] <= '0;
		end else if (wb.valid) begin
			regs[wb.rd[IDX_W-1:0]] <= wb.result;
		end
	end

	// x0 and anything past the file read as zero
	assign rs1_data = (rs1_addr != '0 && int'(rs1_addr) < REG_COUNT) ?
	                  regs[rs1_addr[IDX_W-1:0]] : '0;
	assign rs2_data = (rs2_addr != '0 && int'(rs2_addr) < REG_COUNT) ?
	                  regs[rs2_addr[IDX_W-1:0]] : '0;

	always_ff @(posedge clk) begin
		if (!rst_n)
			out_valid <= 1'b0;
		else
			out_valid <= wb.valid;
	end

	always_ff @(posedge clk) begin
		out_rd <= wb.rd;
		out_result <= wb.result; // mirrors the value just written
	end

	a_rd_in_range: assert property (@(posedge clk) disable iff (!rst_n)
		wb.valid |-> int'(wb.rd) < REG_COUNT);

endmodule

// ==== src/exec_unit.sv ====
`timescale 1ns/1ns

module exec_unit #(
	parameter int REG_COUNT = 32
) (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           in_valid,
	input  common_pkg::u32 in_instr,
	output logic           out_valid,
	output common_pkg::u5  out_rd,
	output common_pkg::u64 out_result
);
	import common_pkg::*;

	u5    rs1_addr;
	u5    rs2_addr;
	u64   rs1_data;
	u64   rs2_data;
	logic ex_fwd_valid;
	u5    ex_fwd_rd;
	u64   ex_fwd_result;

	dec_if dec_bus ();
	wb_if  wb_bus ();

	instr_decode #(
		.REG_COUNT (REG_COUNT)
	) decode_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.in_valid      (in_valid),
		.in_instr      (in_instr),
		.rs1_addr      (rs1_addr),
		.rs2_addr      (rs2_addr),
		.rs1_data      (rs1_data),
		.rs2_data      (rs2_data),
		.ex_fwd_valid  (ex_fwd_valid),
		.ex_fwd_rd     (ex_fwd_rd),
		.ex_fwd_result (ex_fwd_result),
		.dec           (dec_bus.source),
		.wb            (wb_bus.monitor)
	);

	exec_stage exec_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.dec           (dec_bus.sink),
		.wb            (wb_bus.source),
		.ex_fwd_valid  (ex_fwd_valid),
		.ex_fwd_rd     (ex_fwd_rd),
		.ex_fwd_result (ex_fwd_result)
	);

	reg_writeback #(
		.REG_COUNT (REG_COUNT)
	) writeback_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.rs1_addr   (rs1_addr),
		.rs2_addr   (rs2_addr),
		.wb         (wb_bus.sink),
		.rs1_data   (rs1_data),
		.rs2_data   (rs2_data),
		.out_valid  (out_valid),
		.out_rd     (out_rd),
		.out_result (out_result)
	);

endmodule

// ==== sim/tb_exec_unit.sv ====
`timescale 1ns/1ns

module tb_exec_unit;
	import pipes_pkg::*;

	localparam int RESET_CYCLES = 5;
	localparam int STIM_CYCLES = 400;
	localparam int DIRECTED_CYCLES = 11;
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + STIM_CYCLES + 20;

	logic        clk = 1'b0;
	logic        rst_n;
	logic        in_valid;
	logic [31:0] in_instr;
	logic        out_valid;
	logic [4:0]  out_rd;
	logic [63:0] out_result;

	logic [31:0] rng = 32'd42;
	logic [63:0] shadow [32]; // architectural state in program order
	int          cycle_count = 0;
	int          n_expected = 0;
	int          n_retired = 0;

	// expectation for the word now on the inputs
	logic        nxt_valid;
	logic [4:0]  nxt_rd;
	logic [63:0] nxt_result;
	logic        nxt_wform;

	// expected writes in flight with entry 2 due at the outputs
	logic        exp_valid [3];
	logic [4:0]  exp_rd [3];
	logic [63:0] exp_result [3];
	logic        exp_wform [3];

	exec_unit dut_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_instr   (in_instr),
		.out_valid  (out_valid),
		.out_rd     (out_rd),
		.out_result (out_result)
	);

	always #2 clk = ~clk;

	function automatic logic [31:0] roll();
		rng = rng * 32'd1103515245 + 32'd12345;
		return {rng[15:0], rng[31:16]}; // low lcg bits are weak
	endfunction

	// mostly x1..x7 so results feed each other
	function automatic logic [4:0] pick_reg(logic [31:0] r);
		if (r[3:0] < 4'd12)
			return 5'd1 + 5'(r[7:4] % 4'd7);
		else if (r[3:0] == 4'd12)
			return 5'd0;
		else
			return r[8:4];
	endfunction

	function automatic logic is_supported(logic [31:0] w);
		case (w[6:0])
			OPC_OP, OPC_OP_IMM, OPC_LUI: return 1'b1;
			OPC_OP_32, OPC_OP_IMM_32: return w[14:12] inside {3'b000, 3'b001, 3'b101};
			default: return 1'b0;
		endcase
	endfunction

	// rv64i result rules for the kept instruction classes
	function automatic logic [63:0] model_result(logic [31:0] w, logic [63:0] a,
			logic [63:0] b);
		logic [63:0] src2;
		logic [31:0] lo;
		src2 = (w[6:0] == OPC_OP_IMM || w[6:0] == OPC_OP_IMM_32) ?
		       {{52{w[31]}}, w[31:20]} : b;
		lo = '0;
		case (w[6:0])
			OPC_LUI: return {{32{w[31]}}, w[31:12], 12'h000};
			OPC_OP, OPC_OP_IMM: begin
				case (w[14:12])
					3'b000: return (w[6:0] == OPC_OP && w[30]) ? a - src2 : a + src2;
					3'b001: return a << src2[5:0];
					3'b010: return {63'b0, $signed(a) < $signed(src2)};
					3'b011: return {63'b0, a < src2};
					3'b100: return a ^ src2;
					3'b101: begin
						if (w[30])
							return $signed(a) >>> src2[5:0];
						else
							return a >> src2[5:0];
					end
					3'b110: return a | src2;
					default: return a & src2;
				endcase
			end
			default: begin
				if (w[14:12] == 3'b000)
					lo = (w[6:0] == OPC_OP_32 && w[30]) ? a[31:0] - src2[31:0] :
					     a[31:0] + src2[31:0];
				else if (w[14:12] == 3'b001)
					lo = a[31:0] << src2[4:0];
				else if (w[30])
					lo = $signed(a[31:0]) >>> src2[4:0];
				else
					lo = a[31:0] >> src2[4:0];
				return {{32{lo[31]}}, lo};
			end
		endcase
	endfunction

	// update the shadow file and present the word on one edge
	task automatic step(input logic v, input logic [31:0] w);
		logic        wr;
		logic [63:0] res;
		@(posedge clk);
		res = model_result(w, shadow[w[19:15]], shadow[w[24:20]]);
		wr = v && is_supported(w) && (w[11:7] != 5'd0);
		if (wr) begin
			shadow[w[11:7]] = res;
			n_expected++;
		end
		in_valid <= v;
		in_instr <= w;
		nxt_valid <= wr;
		nxt_rd <= w[11:7];
		nxt_result <= res;
		nxt_wform <= (w[6:0] == OPC_OP_32 || w[6:0] == OPC_OP_IMM_32);
	endtask

	task automatic run_directed();
		step(1'b1, {20'h7ffff, 5'd1, OPC_LUI});                          // x1 = 0x7ffff000
		step(1'b1, {12'h7ff, 5'd1, 3'b000, 5'd2, OPC_OP_IMM_32});        // addiw at dist 1
		step(1'b1, {7'h00, 5'd2, 5'd2, 3'b000, 5'd3, OPC_OP_32});        // addw sets bit 31
		step(1'b1, {7'h00, 5'd3, 5'd1, 3'b000, 5'd4, OPC_OP});           // dist 1 and 3
		step(1'b1, {7'h20, 5'd2, 5'd4, 3'b000, 5'd5, OPC_OP});           // sub
		step(1'b1, {7'h00, 5'd5, 5'd4, 3'b100, 5'd6, OPC_OP});           // dist 1 and 2
		step(1'b1, {12'd5, 5'd6, 3'b000, 5'd0, OPC_OP_IMM});             // rd 0
		step(1'b1, {12'd0, 5'd1, 3'b011, 5'd7, 7'b0000011});             // load is dropped
		step(1'b0, {7'h00, 5'd1, 5'd1, 3'b000, 5'd7, OPC_OP});           // idle cycle
		step(1'b1, {7'h20, 5'd4, 5'd3, 3'b101, 5'd1, OPC_OP_IMM_32});    // sraiw
		step(1'b1, {6'h00, 6'd33, 5'd6, 3'b001, 5'd7, OPC_OP_IMM});      // slli by 33
	endtask

	task automatic run_random(input int count);
		logic        v;
		logic [31:0] w;
		logic [31:0] r;
		logic [31:0] s;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [2:0]  f3;
		logic [6:0]  f7;
		logic [11:0] imm;
		for (int n = 0; n < count; n++) begin
			rd = pick_reg(roll());
			rs1 = pick_reg(roll());
			rs2 = pick_reg(roll());
			r = roll();
			s = roll();
			v = (s[3:0] != 4'd0); // about one idle in sixteen
			imm = r[22:11];
			f3 = r[2:0];
			f7 = r[10] ? 7'b0100000 : 7'b0000000;
			if (s[7:4] >= 4'd10 && s[7:4] <= 4'd13)
				f3 = (s[9:8] == 2'd0) ? 3'b000 : (s[9:8] == 2'd1) ? 3'b001 :
				     (s[9:8] == 2'd2) ? 3'b101 : r[2:0]; // w group with some unsupported
			if (f3 != 3'b000 && f3 != 3'b101)
				f7 = 7'b0000000;
			if (s[7:4] <= 4'd4)
				w = {f7, rs2, rs1, f3, rd, OPC_OP};
			else if (s[7:4] <= 4'd9) begin
				if (f3 == 3'b001 || f3 == 3'b101)
					imm = {f7[6:1], imm[5:0]};
				w = {imm, rs1, f3, rd, OPC_OP_IMM};
			end else if (s[7:4] <= 4'd11)
				w = {f7, rs2, rs1, f3, rd, OPC_OP_32};
			else if (s[7:4] <= 4'd13) begin
				if (f3 == 3'b001 || f3 == 3'b101)
					imm = {f7, imm[4:0]};
				w = {imm, rs1, f3, rd, OPC_OP_IMM_32};
			end else if (s[7:4] == 4'd14)
				w = {r[31:12], rd, OPC_LUI};
			else
				w = {r[31:12], rd, s[10] ? 7'b0000011 : 7'b1100011};
			step(v, w);
		end
	endtask

	task automatic report_mismatch(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		$display("[ERROR] time %0t: %s expected %h, got %h", $time, name, expected, actual);
		$display("STATUS: FAIL");
		$fatal(1, "value check failed");
	endtask

	always @(posedge clk) begin
		exp_valid[0] <= nxt_valid;
		exp_rd[0] <= nxt_rd;
		exp_result[0] <= nxt_result;
		exp_wform[0] <= nxt_wform;
		for (int k = 1; k < 3; k++) begin
			exp_valid[k] <= exp_valid[k-1];
			exp_rd[k] <= exp_rd[k-1];
			exp_result[k] <= exp_result[k-1];
			exp_wform[k] <= exp_wform[k-1];
		end
	end

	// outputs only move on the rising edge
	reset_quiet: assert property (@(negedge clk) !rst_n |-> !out_valid)
		else report_mismatch("out_valid", 64'd0, 64'(out_valid));

	valid_match: assert property (@(negedge clk) disable iff (!rst_n)
		out_valid == exp_valid[2])
		else report_mismatch("out_valid", 64'(exp_valid[2]), 64'(out_valid));

	rd_match: assert property (@(negedge clk) disable iff (!rst_n)
		(out_valid && exp_valid[2]) |-> out_rd == exp_rd[2])
		else report_mismatch("out_rd", 64'(exp_rd[2]), 64'(out_rd));

	result_match: assert property (@(negedge clk) disable iff (!rst_n)
		(out_valid && exp_valid[2]) |-> out_result == exp_result[2])
		else report_mismatch("out_result", exp_result[2], out_result);

	// upper half must copy bit 31 of the expected 32-bit result
	wform_sext: assert property (@(negedge clk) disable iff (!rst_n)
		(out_valid && exp_valid[2] && exp_wform[2]) |->
		out_result[63:32] == {32{exp_result[2][31]}})
		else report_mismatch("out_result[63:32]", 64'({32{exp_result[2][31]}}),
			64'(out_result[63:32]));

	always @(negedge clk) begin
		if (rst_n && out_valid)
			n_retired <= n_retired + 1;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout: run still going after %0d cycles", cycle_count);
			$display("STATUS: FAIL");
			$fatal(1, "timeout");
		end
	end

	initial begin
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_instr = '0;
		nxt_valid = 1'b0;
		nxt_rd = '0;
		nxt_result = '0;
		nxt_wform = 1'b0;
		foreach (shadow[k])
			shadow[k] = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		run_directed();
		run_random(STIM_CYCLES - DIRECTED_CYCLES);
		@(posedge clk);
		in_valid <= 1'b0;
		nxt_valid <= 1'b0;
		repeat (4) @(posedge clk); // drain the pipe
		if (n_retired != n_expected) begin
			$display("%0d writes retired but %0d were issued", n_retired, n_expected);
			$display("STATUS: FAIL");
			$fatal(1, "write count mismatch");
		end else begin
			$display("STATUS: PASS");
			$finish;
		end
	end

endmodule

// ==== list.f ====
src/common_pkg.sv
src/pipes_pkg.sv
src/pipe_if.sv
src/alu.sv
src/instr_decode.sv
src/exec_stage.sv
src/reg_writeback.sv
src/exec_unit.sv
sim/tb_exec_unit.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_exec_unit
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?=

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary --assert $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
